// File: iotdf_pkg.sv
package iotdf_pkg;

  // data path widths
  localparam int BYTE_W          = 8;
  localparam int WORD_W          = 128;
  localparam int BYTES_PER_WORD  = WORD_W / BYTE_W;
  localparam int WORDS_PER_GROUP = 8;

  // crc-3, polynomial x^3 + x + 1 without the implicit top term
  localparam int CRC_W = 3;
  localparam logic [CRC_W-1:0] CRC_POLY = 3'b011;

  // function select codes
  localparam int FN_W = 3;
  localparam logic [FN_W-1:0] FN_CRC_GEN  = 3'd3;
  localparam logic [FN_W-1:0] FN_TOP2MAX  = 3'd4;
  localparam logic [FN_W-1:0] FN_LAST2MIN = 3'd5;

  // one data word, seen either as bytes or as a single unsigned number
  // bytes[15] is the most significant byte and the first one to arrive
  typedef union packed {
    logic [BYTES_PER_WORD-1:0][BYTE_W-1:0] bytes;
    logic [WORD_W-1:0]                     value;
  } iot_word_t;

endpackage

// File: iot_byte_loader.sv
`timescale 1ns/1ns

module iot_byte_loader
  import iotdf_pkg::*;
(
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_in_en,
  input  logic [BYTE_W-1:0] i_byte,
  output iot_word_t         o_word,
  output logic              o_word_valid
);

  localparam int CNT_W = $clog2(BYTES_PER_WORD);

  logic [CNT_W-1:0] byte_cnt;
  logic [CNT_W-1:0] byte_idx;
  logic             last_byte;
  iot_word_t        fill_q;
  iot_word_t        fill_d;

  // first byte lands in the top slot
  assign byte_idx  = CNT_W'(BYTES_PER_WORD - 1) - byte_cnt;
  assign last_byte = i_in_en && (byte_cnt == CNT_W'(BYTES_PER_WORD - 1));

  always_comb begin
    fill_d = fill_q;
    fill_d.bytes[byte_idx] = i_byte;
  end

  always_ff @(posedge clk or posedge i_rst) begin
    if (i_rst) begin
      byte_cnt     <= '0;
      o_word_valid <= 1'b0;
    end else begin
      o_word_valid <= last_byte;
      if (i_in_en) begin
        // wraps to zero after the sixteenth byte
        byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  // assembly register and the completed word handed to the core
  always_ff @(posedge clk) begin
    if (i_in_en) begin
      fill_q <= fill_d;
    end
    if (last_byte) begin
      o_word <= fill_d;
    end
  end

  // a word takes sixteen bytes, so strobes are always spaced apart
  a_word_valid_single : assert property (
    @(posedge clk) disable iff (i_rst)
    o_word_valid |=> !o_word_valid
  );

endmodule

// File: iot_crc3.sv
`timescale 1ns/1ns

module iot_crc3
  import iotdf_pkg::*;
(
  input  iot_word_t         i_word,
  output logic [CRC_W-1:0]  o_crc
);

  logic [CRC_W-1:0] rem;
  logic             feedback;

  // bitwise long division, msb first, zero seed
  // the result equals word * x^3 mod (x^3 + x + 1)
  always_comb begin
    rem      = '0;
    feedback = 1'b0;
    for (int i = WORD_W - 1; i >= 0; i--) begin
      feedback = rem[CRC_W-1] ^ i_word.value[i];
      rem      = {rem[CRC_W-2:0], 1'b0};
      if (feedback) begin
        rem = rem ^ CRC_POLY;
      end
    end
  end

  // no final inversion
  assign o_crc = rem;

endmodule

// File: iot_extreme_pair.sv
`timescale 1ns/1ns

module iot_extreme_pair
  import iotdf_pkg::*;
(
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_word_valid,
  input  iot_word_t         i_word,
  input  logic              i_find_max,
  output logic [WORD_W-1:0] o_result,
  output logic              o_result_valid
);

  localparam int CNT_W = $clog2(WORDS_PER_GROUP);

  logic [WORD_W-1:0] primary;
  logic [WORD_W-1:0] secondary;
  logic [CNT_W-1:0]  word_cnt;
  logic              first_word;
  logic              last_word;
  logic              beyond_primary;
  logic              beyond_secondary;
  logic              unload_first;
  logic              unload_second;

  assign first_word = (word_cnt == '0);
  assign last_word  = i_word_valid && (word_cnt == CNT_W'(WORDS_PER_GROUP - 1));

  // strict compare, so equal words never displace a held one
  assign beyond_primary = i_find_max ? (i_word.value > primary)
                                     : (i_word.value < primary);
  assign beyond_secondary = i_find_max ? (i_word.value > secondary)
                                       : (i_word.value < secondary);

  always_ff @(posedge clk or posedge i_rst) begin
    if (i_rst) begin
      word_cnt      <= '0;
      unload_first  <= 1'b0;
      unload_second <= 1'b0;
    end else begin
      // two-cycle unload right after the group's last word is folded in
      unload_first  <= last_word;
      unload_second <= unload_first;
      if (i_word_valid) begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_word_valid) begin
      if (first_word) begin
        primary <= i_word.value;
        // preset so that any real word can win the second place
        secondary <= i_find_max ? '0 : '1;
      end else if (beyond_primary) begin
        primary   <= i_word.value;
        secondary <= primary;
      end else if (beyond_secondary) begin
        secondary <= i_word.value;
      end
    end
  end

  // primary first, then secondary
  assign o_result       = unload_first ? primary : secondary;
  assign o_result_valid = unload_first || unload_second;

  // the loader needs sixteen cycles per word, far more than the unload
  a_no_word_in_unload : assert property (
    @(posedge clk) disable iff (i_rst)
    (unload_first || unload_second) |-> !i_word_valid
  );

endmodule

// File: iot_filter_core.sv
`timescale 1ns/1ns

module iot_filter_core
  import iotdf_pkg::*;
(
  input  logic              clk,
  input  logic              i_rst,
  input  logic [FN_W-1:0]   i_fn_sel,
  input  logic              i_word_valid,
  input  iot_word_t         i_word,
  output logic              o_valid,
  output logic [WORD_W-1:0] o_iot_out
);

  logic              crc_mode;
  logic              minmax_mode;
  logic [CRC_W-1:0]  crc;
  logic [WORD_W-1:0] pair_result;
  logic              pair_valid;
  logic              take_crc;
  logic              take_pair;

  // only the crc, max and min codes produce results
  assign crc_mode    = (i_fn_sel == FN_CRC_GEN);
  assign minmax_mode = (i_fn_sel == FN_TOP2MAX) || (i_fn_sel == FN_LAST2MIN);

  iot_crc3 u_crc3 (
    .i_word (i_word),
    .o_crc  (crc)
  );

  // tracker only sees words in the min/max modes
  iot_extreme_pair u_extreme_pair (
    .clk            (clk),
    .i_rst          (i_rst),
    .i_word_valid   (i_word_valid && minmax_mode),
    .i_word         (i_word),
    .i_find_max     (i_fn_sel == FN_TOP2MAX),
    .o_result       (pair_result),
    .o_result_valid (pair_valid)
  );

  assign take_crc  = crc_mode && i_word_valid;
  assign take_pair = minmax_mode && pair_valid;

  always_ff @(posedge clk or posedge i_rst) begin
    if (i_rst) begin
      o_valid   <= 1'b0;
      o_iot_out <= '0;
    end else begin
      o_valid <= take_crc || take_pair;
      if (take_crc) begin
        o_iot_out <= WORD_W'(crc);
      end else if (take_pair) begin
        o_iot_out <= pair_result;
      end
    end
  end

  // a result under an unsupported code means the code moved without a reset
  a_silent_on_unsupported : assert property (
    @(posedge clk) disable iff (i_rst)
    !(crc_mode || minmax_mode) |-> !o_valid && !pair_valid
  );

endmodule

// File: iotdf_top.sv
`timescale 1ns/1ns

module iotdf_top
  import iotdf_pkg::*;
(
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_in_en,
  input  logic [BYTE_W-1:0] i_iot_in,
  input  logic [FN_W-1:0]   i_fn_sel,
  output logic              o_valid,
  output logic [WORD_W-1:0] o_iot_out
);

  logic      word_valid;
  iot_word_t word;

  // byte stream to 128-bit words
  iot_byte_loader u_byte_loader (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_in_en      (i_in_en),
    .i_byte       (i_iot_in),
    .o_word       (word),
    .o_word_valid (word_valid)
  );

  // crc or min/max selection on complete words
  iot_filter_core u_filter_core (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_fn_sel     (i_fn_sel),
    .i_word_valid (word_valid),
    .i_word       (word),
    .o_valid      (o_valid),
    .o_iot_out    (o_iot_out)
  );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
  input  logic i_rst_req,
  output logic clk,
  output logic o_rst
);

  localparam int HALF_PERIOD = 10;
  localparam int RST_CYCLES  = 4;
  localparam int RST_RELEASE = 2;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // reset at time zero, then again on every request
  initial begin
    o_rst = 1'b1;
    forever begin
      repeat (RST_CYCLES) @(posedge clk);
      #RST_RELEASE o_rst = 1'b0;
      @(posedge i_rst_req);
      o_rst = 1'b1;
    end
  end

endmodule

// File: tb_iotdf.sv
`timescale 1ns/1ns

module tb_iotdf
  import iotdf_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DELAY  = 2;
  localparam int MAX_GAP      = 3;
  localparam int RESULT_WAIT  = 20;
  localparam int DRAIN_CYCLES = 4;
  localparam int RAND_SEED    = 91436;

  logic              clk;
  logic              rst;
  logic              rst_req;
  logic              in_en;
  logic [BYTE_W-1:0] iot_in;
  logic [FN_W-1:0]   fn_sel;
  logic              valid;
  logic [WORD_W-1:0] iot_out;

  // vector file contents, split into sections at each reset line
  logic [WORD_W-1:0] words[$];
  logic [WORD_W-1:0] exps[$];
  logic [FN_W-1:0]   sec_code[$];
  int                sec_word_start[$];
  int                sec_exp_start[$];
  bit                vectors_loaded = 1'b0;

  logic [WORD_W-1:0] got_data[$];
  longint            got_cyc[$];
  longint            exp_cyc[$];
  longint            cyc = 0;
  int                errors = 0;
  int                checks = 0;

  tb_clock_gen u_clock_gen (
    .i_rst_req (rst_req),
    .clk       (clk),
    .o_rst     (rst)
  );

  iotdf_top u_iotdf_top (
    .clk       (clk),
    .i_rst     (rst),
    .i_in_en   (in_en),
    .i_iot_in  (iot_in),
    .i_fn_sel  (fn_sel),
    .o_valid   (valid),
    .o_iot_out (iot_out)
  );

  // cyc counts the rising edges seen so far
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // results are sampled mid-cycle
  always @(negedge clk) begin
    if (!rst && valid) begin
      got_data.push_back(iot_out);
      got_cyc.push_back(cyc);
    end
  end

  task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic load_vectors;
    int                fd;
    int                c;
    int                n;
    logic [WORD_W-1:0] val;

    fd = $fopen("iotdf_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open iotdf_vectors.txt for reading");
      return;
    end
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == "#") begin
        while (c != "\n" && c != -1) begin
          c = $fgetc(fd);
        end
      end else if (c == "R" || c == "W" || c == "E") begin
        n = $fscanf(fd, "%h", val);
        if (n != 1) begin
          errors++;
          $display("vector file line of type %c has no readable hex value", c);
        end else if (c == "R") begin
          sec_code.push_back(val[FN_W-1:0]);
          sec_word_start.push_back(words.size());
          sec_exp_start.push_back(exps.size());
        end else if (c == "W") begin
          words.push_back(val);
        end else begin
          exps.push_back(val);
        end
      end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
        errors++;
        $display("unexpected character %c in vector file", c);
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  // new function code is applied while reset is held
  task automatic restart_dut(input logic [FN_W-1:0] code, input bit first);
    if (!first) begin
      rst_req = 1'b1;
      wait (rst);
      rst_req = 1'b0;
    end
    fn_sel = code;
    wait (!rst);
    @(posedge clk);
    #DRIVE_DELAY;
    check_value("o_valid after reset", WORD_W'(valid), '0);
    check_value("o_iot_out after reset", iot_out, '0);
  endtask

  task automatic drive_word(input logic [WORD_W-1:0] w, output longint last_edge);
    int gap;

    for (int b = BYTES_PER_WORD - 1; b >= 0; b--) begin
      gap   = $urandom_range(MAX_GAP, 0);
      in_en = 1'b0;
      repeat (gap) begin
        @(posedge clk);
        #DRIVE_DELAY;
      end
      in_en     = 1'b1;
      iot_in    = w[b*BYTE_W +: BYTE_W];
      // taken on the coming edge
      last_edge = cyc + 1;
      @(posedge clk);
      #DRIVE_DELAY;
    end
    in_en = 1'b0;
  endtask

  task automatic run_section(input int s);
    logic [FN_W-1:0] code;
    int              w_first;
    int              w_last;
    int              e_first;
    int              n_exp;
    int              waited;
    longint          last_edge;
    bit              minmax;

    code    = sec_code[s];
    w_first = sec_word_start[s];
    w_last  = (s + 1 < sec_code.size()) ? sec_word_start[s + 1] : words.size();
    e_first = sec_exp_start[s];
    n_exp   = ((s + 1 < sec_code.size()) ? sec_exp_start[s + 1] : exps.size()) - e_first;
    minmax  = (code == FN_TOP2MAX) || (code == FN_LAST2MIN);

    restart_dut(code, s == 0);
    got_data.delete();
    got_cyc.delete();
    exp_cyc.delete();

    for (int i = w_first; i < w_last; i++) begin
      drive_word(words[i], last_edge);
      // crc lands one edge after the last byte, min/max two and three
      if (code == FN_CRC_GEN) begin
        exp_cyc.push_back(last_edge + 1);
      end else if (minmax && (i - w_first) % WORDS_PER_GROUP == WORDS_PER_GROUP - 1) begin
        exp_cyc.push_back(last_edge + 2);
        exp_cyc.push_back(last_edge + 3);
      end
    end

    waited = 0;
    while (got_data.size() < n_exp && waited < RESULT_WAIT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
    end
    // a few more cycles to catch anything extra
    repeat (DRAIN_CYCLES) begin
      @(posedge clk);
    end
    #DRIVE_DELAY;

    if (exp_cyc.size() != n_exp) begin
      errors++;
      $display("section %0d lists %0d results but its words call for %0d",
               s, n_exp, exp_cyc.size());
    end
    if (got_data.size() < n_exp) begin
      errors++;
      $display("section %0d with code %0d gave only %0d of %0d expected results",
               s, code, got_data.size(), n_exp);
    end else if (got_data.size() > n_exp) begin
      errors++;
      $display("section %0d with code %0d gave %0d results where %0d were expected",
               s, code, got_data.size(), n_exp);
    end
    for (int k = 0; k < n_exp && k < got_data.size(); k++) begin
      check_value($sformatf("o_iot_out sec%0d[%0d]", s, k), got_data[k], exps[e_first + k]);
      if (k < exp_cyc.size()) begin
        check_value($sformatf("o_valid cycle sec%0d[%0d]", s, k),
                    WORD_W'(got_cyc[k]), WORD_W'(exp_cyc[k]));
      end
    end
  endtask

  initial begin
    rst_req = 1'b0;
    in_en   = 1'b0;
    iot_in  = '0;
    fn_sel  = '0;
    void'($urandom(RAND_SEED));
    load_vectors();
    vectors_loaded = 1'b1;
    for (int s = 0; s < sec_code.size(); s++) begin
      run_section(s);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // worst case is four cycles per byte plus margin for resets and drains
  initial begin
    longint limit_ns;

    wait (vectors_loaded);
    limit_ns = (longint'(words.size()) * BYTES_PER_WORD * (MAX_GAP + 1) + 200) * CLK_PERIOD;
    #(limit_ns);
    errors++;
    $display("watchdog expired after %0d ns with the vector run still going", limit_ns);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: iotdf_vectors.txt
# R <code>: reset the DUT with this function code (hex)
# W <word>: input word, 32 hex digits, sent msb first; E <word>: expected result in order
# crc-3 of single words
R 3
W 00000000000000000000000000000000
W ffffffffffffffffffffffffffffffff
W 00000000000000000000000000000001
W 80000000000000000000000000000000
W 00000000000000010000000000000000
W 00000000000000000000000000000004
W 000000000000000000000000000000a5
W 00000000000000000000000000000018
E 00000000000000000000000000000000
E 00000000000000000000000000000005
E 00000000000000000000000000000003
E 00000000000000000000000000000006
E 00000000000000000000000000000006
E 00000000000000000000000000000007
E 00000000000000000000000000000005
E 00000000000000000000000000000004
# top two max over three groups, first group has a duplicated maximum
R 4
W 00000000000000000000000000000010
W 0000000000000000000000000000ff00
W 00000000000000000000000000000003
W 0000000000000000000000000000ff00
W 00000000000000000000000000000500
W 00000000000000000000000000000001
W 00000000000000000000000000000020
W 00000000000000000000000000000007
W 80000000000000000000000000000000
W 7fffffffffffffffffffffffffffffff
W ffffffffffffffffffffffffffffffff
W 00000000000000000000000000000001
W fffffffffffffffffffffffffffffffe
W 123456789abcdef00fedcba987654321
W 00000000000000000000000000000000
W 80000000000000000000000000000001
W 00000000000000000000000000000900
W 00000000000000000000000000000001
W 00000000000000000000000000000002
W 00000000000000000000000000000003
W 00000000000000000000000000000004
W 00000000000000000000000000000005
W 00000000000000000000000000000006
W 00000000000000000000000000000800
E 0000000000000000000000000000ff00
E 0000000000000000000000000000ff00
E ffffffffffffffffffffffffffffffff
E fffffffffffffffffffffffffffffffe
E 00000000000000000000000000000900
E 00000000000000000000000000000800
# last two min, all-ones words and a group of equal words
R 5
W ffffffffffffffffffffffffffffffff
W 00000000000000000000000000001000
W 00000000000000000000000000000300
W ffffffffffffffffffffffffffffffff
W 00000000000000000000000000000200
W 00000000000000000000000000005000
W 00000000000000000000000000000250
W 7fffffffffffffffffffffffffffffff
W 0123456789abcdef0011223344556677
W 0123456789abcdef0011223344556677
W 0123456789abcdef0011223344556677
W 0123456789abcdef0011223344556677
W 0123456789abcdef0011223344556677
W 0123456789abcdef0011223344556677
W 0123456789abcdef0011223344556677
W 0123456789abcdef0011223344556677
E 00000000000000000000000000000200
E 00000000000000000000000000000250
E 0123456789abcdef0011223344556677
E 0123456789abcdef0011223344556677
# unsupported code, no result expected
R 7
W 00000000000000000000000000000000
W 11111111111111111111111111111111
W 22222222222222222222222222222222
W 33333333333333333333333333333333
W 44444444444444444444444444444444
W 55555555555555555555555555555555
W 66666666666666666666666666666666
W 77777777777777777777777777777777
W 88888888888888888888888888888888
W 99999999999999999999999999999999
W aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa
W bbbbbbbbbbbbbbbbbbbbbbbbbbbbbbbb
W cccccccccccccccccccccccccccccccc
W dddddddddddddddddddddddddddddddd
W eeeeeeeeeeeeeeeeeeeeeeeeeeeeeeee
W ffffffffffffffffffffffffffffffff

// File: sim.f
iotdf_pkg.sv
iot_byte_loader.sv
iot_crc3.sv
iot_extreme_pair.sv
iot_filter_core.sv
iotdf_top.sv
tb_clock_gen.sv
tb_iotdf.sv
